// ==== Makefile ====
SIM        := verilator
TOP        := tb_sdram
RTL_TOP    := sdram_subsys
FILELIST   := compile.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== compile.f ====
sdram_pkg.sv
sdram_model.sv
sdram_init_refresh.sv
sdram_cmd_seq.sv
sdram_dq_io.sv
sdram_subsys.sv
tb_sdram.sv

// ==== sdram_cmd_seq.sv ====
module sdram_cmd_seq import sdram_pkg::*; #(
    parameter int CAS_LATENCY = 2
)(
    input  logic       clk,
    input  logic       rst_n,
    input  host_req_t  req,
    input  logic       req_valid,
    input  logic       init_go,
    input  logic       refresh_due,
    output logic       refresh_ack,
    output sdram_bus_t bus,
    output host_req_t  req_q,
    output logic       wr_go,
    output logic       rd_go,
    output logic       busy,
    output logic       done
);

    // Chip timing in clock cycles
    localparam int T_RP  = 2;
    localparam int T_RCD = 2;
    localparam int T_RFC = 7;
    localparam int T_MRD = 2;

    typedef enum logic [3:0] {
        S_POWER_UP, S_INIT_PRE, S_INIT_REF, S_INIT_MRD,
        S_IDLE, S_REF, S_ACT, S_TRCD, S_BURST, S_TRP
    } state_t;

    state_t     state;
    logic [3:0] dly;
    logic       second_ref;
    // Request taken while a refresh went out first
    logic       pend;

    // Request copy for the whole access
    always_ff @(posedge clk) begin
        if (state == S_IDLE && req_valid)
            req_q <= req;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= S_POWER_UP;
            dly         <= '0;
            second_ref  <= 1'b0;
            pend        <= 1'b0;
            bus         <= '{cmd: CMD_INHIBIT, ba: '0, addr: '0, dqm: 2'b11};
            refresh_ack <= 1'b0;
            wr_go       <= 1'b0;
            rd_go       <= 1'b0;
            busy        <= 1'b1;
            done        <= 1'b0;
        end else begin
            // NOP and quiet strobes unless a state issues something
            bus.cmd     <= CMD_NOP;
            refresh_ack <= 1'b0;
            wr_go       <= 1'b0;
            rd_go       <= 1'b0;
            done        <= 1'b0;
            // Shared gap counter, reloaded by the issuing state
            if (dly != '0)
                dly <= dly - 4'd1;

            case (state)
                S_POWER_UP: begin
                    // Chip deselected until the power-up wait ends
                    bus.cmd <= CMD_INHIBIT;
                    if (init_go) begin
                        bus.cmd      <= CMD_PRECHARGE;
                        bus.addr.col <= '{all_banks: 1'b1, default: '0};
                        dly          <= 4'(T_RP - 1);
                        state        <= S_INIT_PRE;
                    end
                end
                S_INIT_PRE: begin
                    if (dly == '0) begin
                        bus.cmd <= CMD_REFRESH;
                        dly     <= 4'(T_RFC - 1);
                        state   <= S_INIT_REF;
                    end
                end
                S_INIT_REF: begin
                    if (dly == '0 && !second_ref) begin
                        bus.cmd    <= CMD_REFRESH;
                        second_ref <= 1'b1;
                        dly        <= 4'(T_RFC - 1);
                    end else if (dly == '0) begin
                        // Program burst of four and the CAS latency
                        bus.cmd       <= CMD_LOAD_MODE;
                        bus.addr.mode <= '{cas_lat: 3'(CAS_LATENCY),
                                           bl_code: 3'(BL_CODE_4), default: '0};
                        dly           <= 4'(T_MRD - 1);
                        state         <= S_INIT_MRD;
                    end
                end
                S_INIT_MRD: begin
                    if (dly == '0) begin
                        bus.dqm <= 2'b00;
                        busy    <= 1'b0;
                        state   <= S_IDLE;
                    end
                end
                S_IDLE: begin
                    if (req_valid) begin
                        pend <= 1'b1;
                        busy <= 1'b1;
                    end
                    // Pending refresh goes ahead of the request
                    if (refresh_due) begin
                        bus.cmd     <= CMD_REFRESH;
                        refresh_ack <= 1'b1;
                        busy        <= 1'b1;
                        dly         <= 4'(T_RFC - 1);
                        state       <= S_REF;
                    end else if (req_valid) begin
                        state <= S_ACT;
                    end
                end
                S_REF: begin
                    if (dly == '0 && pend) begin
                        state <= S_ACT;
                    end else if (dly == '0) begin
                        busy  <= 1'b0;
                        state <= S_IDLE;
                    end
                end
                S_ACT: begin
                    bus.cmd      <= CMD_ACTIVE;
                    bus.ba       <= req_q.bank;
                    bus.addr.row <= req_q.row;
                    pend         <= 1'b0;
                    dly          <= 4'(T_RCD - 1);
                    state        <= S_TRCD;
                end
                S_TRCD: begin
                    if (dly == '0) begin
                        bus.cmd      <= req_q.write ? CMD_WRITE : CMD_READ;
                        bus.addr.col <= '{col: req_q.col, default: '0};
                        wr_go        <= req_q.write;
                        // Reads wait out the latency before the burst
                        dly          <= req_q.write ? 4'(BURST_WORDS - 1)
                                                    : 4'(CAS_LATENCY + BURST_WORDS - 1);
                        state        <= S_BURST;
                    end
                end
                S_BURST: begin
                    // First read word reaches the bus next cycle
                    if (!req_q.write && dly == 4'(BURST_WORDS))
                        rd_go <= 1'b1;
                    if (dly == '0) begin
                        // Close page after the last word
                        bus.cmd      <= CMD_PRECHARGE;
                        bus.ba       <= req_q.bank;
                        bus.addr.col <= '{all_banks: 1'b0, default: '0};
                        dly          <= 4'(T_RP - 1);
                        state        <= S_TRP;
                    end
                end
                S_TRP: begin
                    if (dly == '0) begin
                        done  <= 1'b1;
                        busy  <= 1'b0;
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Host strobes only while the controller is free
    assert property (@(posedge clk) disable iff (!rst_n) req_valid |-> !busy)
        else $error("request strobe while busy");

    // Burst start must sit on a four-word boundary
    assert property (@(posedge clk) disable iff (!rst_n)
        req_valid |-> (req.col[BURST_IDX_BITS-1:0] == '0))
        else $error("unaligned column 0x%0h", req.col);

endmodule

// ==== sdram_dq_io.sv ====
module sdram_dq_io import sdram_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  host_req_t          req,
    input  logic               wr_go,
    input  logic               rd_go,
    output logic [1:0]         dqm,
    inout  wire [DQ_BITS-1:0]  dq,
    output logic               rd_valid,
    output rd_result_t         rd_data
);

    logic                      wr_act;
    logic [BURST_IDX_BITS-1:0] wr_idx;
    logic                      rd_act;
    logic [BURST_IDX_BITS-1:0] rd_idx;
    logic                      wr_oe;
    logic                      rd_cap;

    // Word 0 goes out on the WRITE cycle itself
    assign wr_oe  = wr_go | wr_act;
    assign rd_cap = rd_go | rd_act;

    assign dq  = wr_oe ? req.wdata[wr_idx] : 'z;
    // Byte mask only matters while write words are on the bus
    assign dqm = wr_oe ? req.mask : 2'b00;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_act   <= 1'b0;
            wr_idx   <= '0;
            rd_act   <= 1'b0;
            rd_idx   <= '0;
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= 1'b0;
            // Index wraps back to zero after the last word
            if (wr_oe) begin
                wr_idx <= wr_idx + BURST_IDX_BITS'(1);
                wr_act <= (wr_idx != BURST_IDX_BITS'(BURST_WORDS - 1));
            end
            if (rd_cap) begin
                rd_idx   <= rd_idx + BURST_IDX_BITS'(1);
                rd_act   <= (rd_idx != BURST_IDX_BITS'(BURST_WORDS - 1));
                rd_valid <= (rd_idx == BURST_IDX_BITS'(BURST_WORDS - 1));
            end
        end
    end

    // Gather read words in burst order
    always_ff @(posedge clk) begin
        if (rd_cap)
            rd_data.words[rd_idx] <= dq;
    end

endmodule

// ==== sdram_init_refresh.sv ====
module sdram_init_refresh #(
    parameter int REFRESH_INTERVAL = 390,
    parameter int INIT_WAIT        = 100
)(
    input  logic clk,
    input  logic rst_n,
    input  logic refresh_ack,
    output logic init_go,
    output logic refresh_due
);

    // One counter serves both the power-up wait and the refresh interval
    localparam int MAX_CNT = (INIT_WAIT > REFRESH_INTERVAL) ? INIT_WAIT : REFRESH_INTERVAL;
    localparam int CNT_W   = $clog2(MAX_CNT + 1);

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt         <= '0;
            init_go     <= 1'b0;
            refresh_due <= 1'b0;
        end else if (!init_go) begin
            // Power-up stabilization wait
            if (cnt == CNT_W'(INIT_WAIT - 1)) begin
                init_go <= 1'b1;
                cnt     <= '0;
            end else begin
                cnt <= cnt + CNT_W'(1);
            end
        end else if (refresh_ack) begin
            // Refresh issued, start a new interval
            refresh_due <= 1'b0;
            cnt         <= '0;
        end else if (cnt == CNT_W'(REFRESH_INTERVAL - 1)) begin
            // Hold the request until the sequencer takes it
            refresh_due <= 1'b1;
        end else begin
            cnt <= cnt + CNT_W'(1);
        end
    end

    // Sequencer refreshes only when asked
    assert property (@(posedge clk) disable iff (!rst_n) refresh_ack |-> refresh_due)
        else $error("refresh_ack without refresh_due");

endmodule

// ==== sdram_model.sv ====
module sdram_model import sdram_pkg::*; (
    input  logic               clk,
    input  sdram_bus_t         bus,
    inout  wire [DQ_BITS-1:0]  dq
);

    typedef enum logic [1:0] {IDLE, WAIT_READ, READING, WRITING} state_t;

    // Storage key is bank, row and column
    localparam int KEY_BITS = BANK_BITS + ROW_BITS + COL_BITS;

    logic [DQ_BITS-1:0]        mem [logic [KEY_BITS-1:0]];
    logic [ROW_BITS-1:0]       open_row [2**BANK_BITS];
    logic [2**BANK_BITS-1:0]   bank_open = '0;

    // Mode register, holds power-on values until LOAD MODE
    logic [2:0]                bl_code = 3'(BL_CODE_4);
    logic [2:0]                cas_lat = 3'd2;

    state_t                    state = IDLE;
    logic [2:0]                dly;
    logic [3:0]                cnt;
    logic [BANK_BITS-1:0]      cur_bank;
    logic [COL_BITS-1:0]       cur_col;
    logic [DQ_BITS-1:0]        dq_out;
    logic                      dq_en = 1'b0;

    // Chip drives the bus only while read words are out
    assign dq = dq_en ? dq_out : 'z;

    // Burst length from mode code, reserved codes fall back to one word
    function automatic logic [3:0] burst_len(logic [2:0] code);
        return (code <= 3'd3) ? (4'd1 << code) : 4'd1;
    endfunction

    function automatic logic [KEY_BITS-1:0] key(logic [BANK_BITS-1:0] b,
                                                logic [COL_BITS-1:0] c);
        return {b, open_row[b], c};
    endfunction

    // Words never written read back as zero
    function automatic logic [DQ_BITS-1:0] fetch(logic [KEY_BITS-1:0] k);
        return mem.exists(k) ? mem[k] : '0;
    endfunction

    // Merge the bytes that DQM leaves unmasked
    task automatic store(logic [KEY_BITS-1:0] k);
        logic [DQ_BITS-1:0] old;
        old = fetch(k);
        mem[k] = {bus.dqm[1] ? old[15:8] : dq[15:8],
                  bus.dqm[0] ? old[7:0]  : dq[7:0]};
    endtask

    always @(posedge clk) begin
        // Mode and bank bookkeeping
        case (bus.cmd)
            CMD_LOAD_MODE: begin
                bl_code <= bus.addr.mode.bl_code;
                cas_lat <= bus.addr.mode.cas_lat;
            end
            CMD_ACTIVE: begin
                open_row[bus.ba]  <= bus.addr.row;
                bank_open[bus.ba] <= 1'b1;
            end
            CMD_PRECHARGE: begin
                if (bus.addr.col.all_banks)
                    bank_open <= '0;
                else
                    bank_open[bus.ba] <= 1'b0;
            end
            default: ;
        endcase

        case (state)
            IDLE: begin
                if (bus.cmd == CMD_READ) begin
                    // First word leaves one cycle short of the latency
                    dly      <= cas_lat - 3'd1;
                    cur_bank <= bus.ba;
                    cur_col  <= bus.addr.col.col;
                    state    <= WAIT_READ;
                end else if (bus.cmd == CMD_WRITE) begin
                    // Word 0 arrives together with the command
                    store(key(bus.ba, bus.addr.col.col));
                    cur_bank <= bus.ba;
                    cur_col  <= bus.addr.col.col + COL_BITS'(1);
                    cnt      <= burst_len(bl_code) - 4'd1;
                    state    <= (burst_len(bl_code) > 4'd1) ? WRITING : IDLE;
                end
            end
            WAIT_READ: begin
                if (dly <= 3'd1) begin
                    dq_out  <= fetch(key(cur_bank, cur_col));
                    dq_en   <= 1'b1;
                    cur_col <= cur_col + COL_BITS'(1);
                    cnt     <= burst_len(bl_code) - 4'd1;
                    state   <= READING;
                end else begin
                    dly <= dly - 3'd1;
                end
            end
            READING: begin
                if (cnt != 4'd0) begin
                    dq_out  <= fetch(key(cur_bank, cur_col));
                    cur_col <= cur_col + COL_BITS'(1);
                    cnt     <= cnt - 4'd1;
                end else begin
                    // Burst over, back to high impedance
                    dq_en <= 1'b0;
                    state <= IDLE;
                end
            end
            WRITING: begin
                store(key(cur_bank, cur_col));
                cur_col <= cur_col + COL_BITS'(1);
                cnt     <= cnt - 4'd1;
                if (cnt <= 4'd1)
                    state <= IDLE;
            end
            default: state <= IDLE;
        endcase
    end

    // Column accesses only to a bank whose row is open
    assert property (@(posedge clk)
        (bus.cmd inside {CMD_READ, CMD_WRITE}) |-> bank_open[bus.ba])
        else $error("column access to bank %0d with no open row", bus.ba);

endmodule

// ==== sdram_pkg.sv ====
package sdram_pkg;

    // Chip geometry of the 16-bit, 4-bank part
    localparam int ROW_BITS  = 13;
    localparam int COL_BITS  = 9;
    localparam int BANK_BITS = 2;
    localparam int DQ_BITS   = 16;

    // Fixed burst of four words and its mode register code
    localparam int BURST_WORDS    = 4;
    localparam int BURST_IDX_BITS = $clog2(BURST_WORDS);
    localparam int BL_CODE_4      = 2;

    // Command bits in the order cs, ras, cas, we, all active low
    typedef enum logic [3:0] {
        CMD_INHIBIT   = 4'b1111,
        CMD_NOP       = 4'b0111,
        CMD_ACTIVE    = 4'b0011,
        CMD_READ      = 4'b0101,
        CMD_WRITE     = 4'b0100,
        CMD_PRECHARGE = 4'b0010,
        CMD_REFRESH   = 4'b0001,
        CMD_LOAD_MODE = 4'b0000
    } sdram_cmd_t;

    // Mode register layout seen on the address bus during LOAD MODE
    typedef struct packed {
        logic [5:0] rsvd_hi;
        logic [2:0] cas_lat;
        logic       rsvd_lo;
        logic [2:0] bl_code;
    } sdram_mode_t;

    // Column layout for READ and WRITE, bit 10 selects all banks on PRECHARGE
    typedef struct packed {
        logic [1:0]          rsvd_hi;
        logic                all_banks;
        logic                rsvd_lo;
        logic [COL_BITS-1:0] col;
    } sdram_col_t;

    // One address word, three readings depending on the command
    typedef union packed {
        logic [ROW_BITS-1:0] row;
        sdram_mode_t         mode;
        sdram_col_t          col;
    } sdram_addr_u;

    // Control side of the chip bus
    typedef struct packed {
        sdram_cmd_t           cmd;
        logic [BANK_BITS-1:0] ba;
        sdram_addr_u          addr;
        logic [1:0]           dqm;
    } sdram_bus_t;

    // Host request, a set mask bit keeps the old byte
    typedef struct packed {
        logic                                   write;
        logic [BANK_BITS-1:0]                   bank;
        logic [ROW_BITS-1:0]                    row;
        logic [COL_BITS-1:0]                    col;
        logic [1:0]                             mask;
        logic [BURST_WORDS-1:0][DQ_BITS-1:0]    wdata;
    } host_req_t;

    // Read burst, word 0 at index 0
    typedef struct packed {
        logic [BURST_WORDS-1:0][DQ_BITS-1:0] words;
    } rd_result_t;

endpackage

// ==== sdram_subsys.sv ====
module sdram_subsys import sdram_pkg::*; #(
    parameter int CAS_LATENCY      = 2,
    parameter int REFRESH_INTERVAL = 390,
    parameter int INIT_WAIT        = 100
)(
    input  logic       clk,
    input  logic       rst_n,
    input  host_req_t  req,
    input  logic       req_valid,
    output logic       busy,
    output logic       rd_valid,
    output rd_result_t rd_data,
    output logic       done
);

    logic               init_go;
    logic               refresh_due;
    logic               refresh_ack;
    logic               wr_go;
    logic               rd_go;
    logic [1:0]         io_dqm;
    host_req_t          req_q;
    sdram_bus_t         seq_bus;
    sdram_bus_t         chip_bus;
    wire [DQ_BITS-1:0]  dq;

    // Sequencer holds DQM high through init, the data path adds the write mask
    assign chip_bus = '{cmd: seq_bus.cmd, ba: seq_bus.ba, addr: seq_bus.addr,
                        dqm: seq_bus.dqm | io_dqm};

    sdram_init_refresh #(
        .REFRESH_INTERVAL (REFRESH_INTERVAL),
        .INIT_WAIT        (INIT_WAIT)
    ) u_init_refresh (
        .clk, .rst_n, .refresh_ack, .init_go, .refresh_due
    );

    sdram_cmd_seq #(
        .CAS_LATENCY (CAS_LATENCY)
    ) u_cmd_seq (
        .clk, .rst_n, .req, .req_valid, .init_go, .refresh_due, .refresh_ack,
        .bus (seq_bus), .req_q, .wr_go, .rd_go, .busy, .done
    );

    sdram_dq_io u_dq_io (
        .clk, .rst_n, .req (req_q), .wr_go, .rd_go, .dqm (io_dqm), .dq,
        .rd_valid, .rd_data
    );

    // Chip learns its CAS latency from LOAD MODE
    sdram_model u_model (
        .clk, .bus (chip_bus), .dq
    );

endmodule

// ==== tb_sdram.sv ====
module tb_sdram import sdram_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD       = 8;
    localparam int RESET_CYCLES     = 16;
    localparam int CAS_LATENCY      = 2;
    localparam int REFRESH_INTERVAL = 120;
    localparam int INIT_WAIT        = 100;
    localparam logic [31:0] SEED    = 32'hf34cfb00;

    // Address pool shared by the random and idle-gap tests
    localparam int POOL_BITS  = 5;
    localparam int POOL_SIZE  = 2**POOL_BITS;
    localparam int NUM_RANDOM = 300;
    localparam int NUM_GAPS   = 4;
    localparam int KEY_BITS   = BANK_BITS + ROW_BITS + COL_BITS;

    // Requests from the prefill, directed, masked, random and gap tests
    localparam int NUM_REQ         = POOL_SIZE + 2 + 9 + NUM_RANDOM + 2 * NUM_GAPS;
    localparam int INIT_CYCLES     = RESET_CYCLES + INIT_WAIT + 64;
    localparam int WATCHDOG_CYCLES = NUM_REQ * 400 + INIT_CYCLES;

    logic       clk = 1'b0;
    logic       rst_n;
    host_req_t  req;
    logic       req_valid;
    logic       busy;
    logic       rd_valid;
    rd_result_t rd_data;
    logic       done;

    logic [31:0]        lfsr_state = SEED;
    logic [DQ_BITS-1:0] ref_mem [logic [KEY_BITS-1:0]];
    host_req_t          pool [POOL_SIZE];

    always #(CLK_PERIOD / 2) clk = ~clk;

    sdram_subsys #(
        .CAS_LATENCY      (CAS_LATENCY),
        .REFRESH_INTERVAL (REFRESH_INTERVAL),
        .INIT_WAIT        (INIT_WAIT)
    ) u_dut (
        .clk, .rst_n, .req, .req_valid, .busy, .rd_valid, .rd_data, .done
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] galois_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // One LFSR step per bit handed out
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = galois_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [KEY_BITS-1:0] word_key(input host_req_t r, input int i);
        return {r.bank, r.row, r.col + COL_BITS'(i)};
    endfunction

    // Unwritten words read as zero
    function automatic logic [DQ_BITS-1:0] ref_word(input logic [KEY_BITS-1:0] k);
        return ref_mem.exists(k) ? ref_mem[k] : '0;
    endfunction

    // Set mask bit keeps the old byte
    task automatic ref_write(input host_req_t r);
        logic [KEY_BITS-1:0] k;
        logic [DQ_BITS-1:0]  old;
        for (int i = 0; i < BURST_WORDS; i++) begin
            k = word_key(r, i);
            old = ref_word(k);
            ref_mem[k] = {r.mask[1] ? old[15:8] : r.wdata[i][15:8],
                          r.mask[0] ? old[7:0]  : r.wdata[i][7:0]};
        end
    endtask

    function automatic rd_result_t ref_read(input host_req_t r);
        rd_result_t res;
        for (int i = 0; i < BURST_WORDS; i++)
            res.words[i] = ref_word(word_key(r, i));
        return res;
    endfunction

    // Request with fresh random write words
    function automatic host_req_t new_req(input logic write, input logic [BANK_BITS-1:0] bank,
                                          input logic [ROW_BITS-1:0] row,
                                          input logic [COL_BITS-1:0] col,
                                          input logic [1:0] mask);
        host_req_t r;
        r.write = write;
        r.bank  = bank;
        r.row   = row;
        r.col   = col;
        r.mask  = mask;
        for (int i = 0; i < BURST_WORDS; i++)
            r.wdata[i] = DQ_BITS'(take_bits(DQ_BITS));
        return r;
    endfunction

    function automatic host_req_t pool_req(input int idx, input logic write,
                                           input logic [1:0] mask);
        return new_req(write, pool[idx].bank, pool[idx].row, pool[idx].col, mask);
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_rd(input rd_result_t got, input rd_result_t exp);
        if (got !== exp)
            stop_on_error($sformatf("Mismatch rd_data: got 0x%h expected 0x%h", got, exp));
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
            stop_on_error($sformatf("Mismatch %s: got 0x%h expected 0x%h", name, got, exp));
    endtask

    // No access in flight, so no pulses either
    task automatic idle_step();
        check_flag("done", done, 1'b0);
        check_flag("rd_valid", rd_valid, 1'b0);
        @(posedge clk);
        #1;
    endtask

    // Strobe one request, follow it to done and check the result
    task automatic run_access(input host_req_t r);
        rd_result_t got;
        logic       rd_seen;
        logic       finished;
        got      = '0;
        rd_seen  = 1'b0;
        finished = 1'b0;
        while (busy)
            idle_step();
        req       = r;
        req_valid = 1'b1;
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        check_flag("busy", busy, 1'b1);
        while (!finished) begin
            @(posedge clk);
            #1;
            // Busy holds until the access ends
            if (!done)
                check_flag("busy", busy, 1'b1);
            if (rd_valid) begin
                // Writes never pulse and reads pulse once
                if (rd_seen || r.write)
                    check_flag("rd_valid", rd_valid, 1'b0);
                rd_seen = 1'b1;
                got     = rd_data;
            end
            finished = done;
        end
        check_flag("rd_valid", rd_seen, !r.write);
        if (r.write)
            ref_write(r);
        else
            check_rd(got, ref_read(r));
        // done lasts a single cycle
        @(posedge clk);
        #1;
        check_flag("done", done, 1'b0);
        check_flag("rd_valid", rd_valid, 1'b0);
    endtask

    // Long quiet stretch where refresh must still show up as busy
    task automatic idle_gap(input int cycles);
        int busy_cycles;
        busy_cycles = 0;
        for (int i = 0; i < cycles; i++) begin
            if (busy)
                busy_cycles++;
            idle_step();
        end
        if (busy_cycles == 0)
            stop_on_error($sformatf("no refresh seen during an idle gap of %0d cycles", cycles));
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        stop_on_error($sformatf("watchdog expired after %0d cycles", WATCHDOG_CYCLES));
    end

    initial begin
        int        init_cycles;
        int        idx;
        host_req_t r;
        rst_n     = 1'b0;
        req       = '0;
        req_valid = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Busy through the whole init sequence
        check_flag("busy", busy, 1'b1);
        init_cycles = 0;
        while (busy) begin
            idle_step();
            init_cycles++;
        end
        if (init_cycles < INIT_WAIT)
            stop_on_error($sformatf("busy fell after %0d cycles, before the power-up wait",
                                    init_cycles));

        // Plain write then read back
        r = new_req(1'b1, 2'd1, 13'h0123, 9'h040, 2'b00);
        run_access(r);
        r.write = 1'b0;
        run_access(r);

        // Low, high and both bytes masked over a known burst
        for (int m = 1; m < 4; m++) begin
            run_access(new_req(1'b1, 2'd2, 13'h1abc, 9'h1f0, 2'b00));
            run_access(new_req(1'b1, 2'd2, 13'h1abc, 9'h1f0, 2'(m)));
            run_access(new_req(1'b0, 2'd2, 13'h1abc, 9'h1f0, 2'b00));
        end

        // Pool of aligned addresses that are all written before any read
        for (int i = 0; i < POOL_SIZE; i++) begin
            pool[i] = new_req(1'b1, BANK_BITS'(take_bits(BANK_BITS)),
                              ROW_BITS'(take_bits(ROW_BITS)),
                              {7'(take_bits(7)), 2'b00}, 2'b00);
            run_access(pool[i]);
        end

        for (int n = 0; n < NUM_RANDOM; n++) begin
            idx = int'(take_bits(POOL_BITS));
            run_access(pool_req(idx, 1'(take_bits(1)), 2'(take_bits(2))));
        end

        // Accesses separated by several refresh intervals
        for (int g = 0; g < NUM_GAPS; g++) begin
            idx = int'(take_bits(POOL_BITS));
            idle_gap(2 * REFRESH_INTERVAL + int'(take_bits(6)));
            run_access(pool_req(idx, 1'b1, 2'(take_bits(2))));
            idle_gap(2 * REFRESH_INTERVAL + int'(take_bits(6)));
            run_access(pool_req(idx, 1'b0, 2'b00));
        end

        $display("TEST OK");
        $finish;
    end

endmodule
